// File: include/engine_consts.svh
// ------------------------------------------------
// Sizes shared by the engine lane RTL and package.
// Include wherever a field width or depth is needed.
// ------------------------------------------------

`ifndef ENGINE_CONSTS_SVH
`define ENGINE_CONSTS_SVH

// Packet field widths
`define ENGINE_VERTEX_WIDTH 16
`define ENGINE_DATA_WIDTH 32
`define ENGINE_SEQ_WIDTH 16

// Buffering
`define ENGINE_FIFO_DEPTH 16
`define ENGINE_PROG_THRESH 8

// Stand-in processing latency
`define ENGINE_PIPELINE_STAGES 2

`endif

// File: logic/engine_pkg.sv
// ------------------------------------------------
// Packet and FIFO status types for the engine lane.
// Imported by wildcard in each module header.
// ------------------------------------------------

`include "engine_consts.svh"

package engine_pkg;

    // What the engine actually carries
    typedef struct packed {
        logic [`ENGINE_VERTEX_WIDTH-1:0] vertex_id;
        logic [`ENGINE_DATA_WIDTH-1:0]   data;
        logic [`ENGINE_SEQ_WIDTH-1:0]    seq;
    } engine_payload_t;

    // Valid strobe plus payload
    typedef struct packed {
        logic            valid;
        engine_payload_t payload;
    } engine_packet_t;

    // Flags reported by every packet FIFO
    typedef struct packed {
        logic empty;
        logic full;
        logic prog_full;
        logic rd_valid;
    } fifo_status_t;

endpackage

// File: logic/packet_fifo.sv
// ------------------------------------------------
// Synchronous FIFO of engine packets. The write valid
// bit pushes, a pop level reads, and the read packet
// is valid the cycle after an accepted pop.
// ------------------------------------------------

`include "engine_consts.svh"

module packet_fifo
    import engine_pkg::*;
#(
    parameter int DEPTH       = `ENGINE_FIFO_DEPTH,
    parameter int PROG_THRESH = `ENGINE_PROG_THRESH
) (
    input  logic           ap_clk,
    input  logic           areset_template_engine,
    input  engine_packet_t wr_packet,
    input  logic           rd_en,
    output engine_packet_t rd_packet,
    output fifo_status_t   status
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    engine_payload_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    logic push;
    logic pop;

    // ------------------------------------------------
    // Flags and accepted operations
    // ------------------------------------------------
    assign status.empty     = (count == '0);
    assign status.full      = (count == CW'(DEPTH));
    assign status.prog_full = (count >= CW'(PROG_THRESH));
    assign status.rd_valid  = rd_packet.valid;

    // Push while full is dropped, pop while empty ignored
    assign push = wr_packet.valid & ~status.full;
    assign pop  = rd_en & ~status.empty;

    // ------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            count           <= '0;
            rd_packet.valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count           <= count + CW'(push) - CW'(pop);
            rd_packet.valid <= pop;
        end
    end

    // Storage and read data, no reset needed
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_packet.payload;
        end
        if (pop) begin
            rd_packet.payload <= mem[rd_ptr];
        end
    end

    // ------------------------------------------------
    // Checks
    // ------------------------------------------------
    // Upstream back-pressure must keep pushes off a full FIFO
    assert property (@(posedge ap_clk) disable iff (areset_template_engine)
        wr_packet.valid |-> !status.full)
        else $error("packet_fifo: push while full, packet lost");

    assert property (@(posedge ap_clk) disable iff (areset_template_engine)
        !(status.empty && status.full))
        else $error("packet_fifo: empty and full at once");

endmodule

// File: logic/engine_delay_pipeline.sv
// ------------------------------------------------
// Fixed-depth register pipeline standing in for the
// vertex-processing logic; busy flags any live stage.
// ------------------------------------------------

`include "engine_consts.svh"

module engine_delay_pipeline
    import engine_pkg::*;
#(
    parameter int STAGES = `ENGINE_PIPELINE_STAGES
) (
    input  logic           ap_clk,
    input  logic           areset_template_engine,
    input  engine_packet_t in_packet,
    output engine_packet_t out_packet,
    output logic           busy
);

    engine_packet_t stage_q [STAGES];

    // Valid bits reset, payloads just shift
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            for (int i = 0; i < STAGES; i++) begin
                stage_q[i].valid <= 1'b0;
            end
        end else begin
            stage_q[0].valid <= in_packet.valid;
            for (int i = 1; i < STAGES; i++) begin
                stage_q[i].valid <= stage_q[i-1].valid;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        stage_q[0].payload <= in_packet.payload;
        for (int i = 1; i < STAGES; i++) begin
            stage_q[i].payload <= stage_q[i-1].payload;
        end
    end

    assign out_packet = stage_q[STAGES-1];

    always_comb begin
        busy = 1'b0;
        for (int i = 0; i < STAGES; i++) begin
            busy = busy | stage_q[i].valid;
        end
    end

    // Latency is exact and the payload is untouched
    assert property (@(posedge ap_clk) disable iff (areset_template_engine)
        in_packet.valid |-> ##STAGES
            (out_packet.valid && out_packet.payload == $past(in_packet.payload, STAGES)))
        else $error("engine_delay_pipeline: packet did not emerge after STAGES cycles");

endmodule

// File: logic/engine_egress.sv
// ------------------------------------------------
// Egress stage: drains the output FIFO under the
// downstream enable, registers the request port and
// raises done once the whole lane is idle.
// ------------------------------------------------

module engine_egress
    import engine_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_template_engine,
    input  logic           request_rd_en,
    input  engine_packet_t fifo_rd_packet,
    output logic           fifo_pop,
    input  logic           in_fifo_empty,
    input  logic           out_fifo_empty,
    input  logic           pipeline_busy,
    output engine_packet_t request_engine_out,
    output logic           done_out
);

    logic request_rd_en_q;
    logic lane_idle;

    // ------------------------------------------------
    // Downstream enable, one cycle late
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            request_rd_en_q <= 1'b0;
        end else begin
            request_rd_en_q <= request_rd_en;
        end
    end

    // The FIFO itself ignores a pop while empty
    assign fifo_pop = request_rd_en_q;

    // ------------------------------------------------
    // Request port and done
    // ------------------------------------------------
    assign lane_idle = in_fifo_empty & out_fifo_empty & ~pipeline_busy
                     & ~fifo_rd_packet.valid & ~request_engine_out.valid;

    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            request_engine_out.valid <= 1'b0;
            done_out                 <= 1'b0;
        end else begin
            request_engine_out.valid <= fifo_rd_packet.valid;
            done_out                 <= lane_idle;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_engine_out.payload <= fifo_rd_packet.payload;
    end

endmodule

// File: logic/engine_pipeline_top.sv
// ------------------------------------------------
// Engine lane top: input register, input FIFO, delay
// pipeline, output FIFO and egress. Packets leave in
// arrival order; done_out rises when all is drained.
// ------------------------------------------------

`include "engine_consts.svh"

module engine_pipeline_top
    import engine_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset,
    input  engine_packet_t response_engine_in,
    input  logic           response_rd_en,
    input  logic           request_rd_en,
    output engine_packet_t request_engine_out,
    output fifo_status_t   fifo_response_status,
    output logic           done_out
);

    logic           areset_template_engine;
    engine_packet_t response_engine_in_reg;
    logic           response_rd_en_reg;

    engine_packet_t in_rd_packet;
    fifo_status_t   in_status;
    logic           in_pop;
    logic           in_side_empty;

    engine_packet_t pipe_out_packet;
    logic           pipeline_busy;

    engine_packet_t out_rd_packet;
    fifo_status_t   out_status;
    logic           out_pop;

    // ------------------------------------------------
    // Reset and input registering
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        areset_template_engine <= areset;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            response_engine_in_reg.valid <= 1'b0;
            response_rd_en_reg           <= 1'b0;
        end else begin
            response_engine_in_reg.valid <= response_engine_in.valid;
            response_rd_en_reg           <= response_rd_en;
        end
    end

    always_ff @(posedge ap_clk) begin
        response_engine_in_reg.payload <= response_engine_in.payload;
    end

    // Hold input pops while the output FIFO is nearly full
    assign in_pop = response_rd_en_reg & ~out_status.prog_full;

    // Status port, one cycle behind the input FIFO
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            fifo_response_status.empty     <= 1'b1;
            fifo_response_status.full      <= 1'b0;
            fifo_response_status.prog_full <= 1'b0;
            fifo_response_status.rd_valid  <= 1'b0;
        end else begin
            fifo_response_status <= in_status;
        end
    end

    // Nothing queued, nothing being written or read on the input side
    assign in_side_empty = in_status.empty & ~in_rd_packet.valid & ~response_engine_in_reg.valid;

    // ------------------------------------------------
    // Lane instances
    // ------------------------------------------------
    packet_fifo #(
        .DEPTH      (`ENGINE_FIFO_DEPTH),
        .PROG_THRESH(`ENGINE_PROG_THRESH)
    ) input_fifo (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .wr_packet             (response_engine_in_reg),
        .rd_en                 (in_pop),
        .rd_packet             (in_rd_packet),
        .status                (in_status)
    );

    engine_delay_pipeline #(
        .STAGES(`ENGINE_PIPELINE_STAGES)
    ) engine_delay_pipeline (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .in_packet             (in_rd_packet),
        .out_packet            (pipe_out_packet),
        .busy                  (pipeline_busy)
    );

    packet_fifo #(
        .DEPTH      (`ENGINE_FIFO_DEPTH),
        .PROG_THRESH(`ENGINE_PROG_THRESH)
    ) output_fifo (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .wr_packet             (pipe_out_packet),
        .rd_en                 (out_pop),
        .rd_packet             (out_rd_packet),
        .status                (out_status)
    );

    engine_egress engine_egress (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .request_rd_en         (request_rd_en),
        .fifo_rd_packet        (out_rd_packet),
        .fifo_pop              (out_pop),
        .in_fifo_empty         (in_side_empty),
        .out_fifo_empty        (out_status.empty),
        .pipeline_busy         (pipeline_busy),
        .request_engine_out    (request_engine_out),
        .done_out              (done_out)
    );

endmodule

// File: testbench/engine_tb_top.sv
// ------------------------------------------------
// Testbench for the engine lane top. Sends LCG packets,
// checks order and payload on every request strobe and
// reports one line per test plus a closing count line.
// ------------------------------------------------

`include "engine_consts.svh"

module engine_tb_top
    import engine_pkg::*;
();

    localparam logic [31:0] SEED = 32'h8a3f81b9;
    localparam int N_STREAM = 24;
    localparam int N_HOLD = 6;
    localparam int N_BP_MAX = 2 * `ENGINE_FIFO_DEPTH;
    localparam int N_DONE = 4;
    localparam int TIMEOUT_CYCLES = 10 * (N_STREAM + N_HOLD + N_BP_MAX + N_DONE) + 300;

    logic           ap_clk;
    logic           areset;
    engine_packet_t response_engine_in;
    logic           response_rd_en;
    logic           request_rd_en;
    engine_packet_t request_engine_out;
    fifo_status_t   fifo_response_status;
    logic           done_out;

    logic [31:0]     gen_state;
    int              sent_count;
    int              recv_count;
    int              error_count;
    int              test_errors;
    int              test_count;
    int              cycle_count;
    string           test_name;
    engine_payload_t expected_q;

    engine_pipeline_top dut0 (
        .ap_clk              (ap_clk),
        .areset              (areset),
        .response_engine_in  (response_engine_in),
        .response_rd_en      (response_rd_en),
        .request_rd_en       (request_rd_en),
        .request_engine_out  (request_engine_out),
        .fifo_response_status(fifo_response_status),
        .done_out            (done_out)
    );

    initial begin
        ap_clk = 1'b0;
        forever begin
            #50 ap_clk = ~ap_clk;
        end
    end

    // ------------------------------------------------
    // Stimulus and reference model
    // ------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Replays the generator from the seed, two steps per packet
    function automatic engine_payload_t expected_payload(input int n);
        logic [31:0] s;
        engine_payload_t p;
        s = SEED;
        p = '0;
        for (int i = 0; i <= n; i++) begin
            s = lcg_next(s);
            p.vertex_id = s[31:16];
            s = lcg_next(s);
            p.data = s;
        end
        p.seq = n[`ENGINE_SEQ_WIDTH-1:0];
        return p;
    endfunction

    // Drives one new packet; caller is already on a falling edge
    task automatic drive_next_packet();
        gen_state = lcg_next(gen_state);
        response_engine_in.payload.vertex_id = gen_state[31:16];
        gen_state = lcg_next(gen_state);
        response_engine_in.payload.data = gen_state;
        response_engine_in.payload.seq = sent_count[`ENGINE_SEQ_WIDTH-1:0];
        response_engine_in.valid = 1'b1;
        sent_count++;
    endtask

    task automatic send_burst(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge ap_clk);
            drive_next_packet();
        end
        @(negedge ap_clk);
        response_engine_in.valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge ap_clk);
    endtask

    task automatic wait_drained();
        while (recv_count < sent_count) begin
            @(negedge ap_clk);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = error_count;
    endtask

    task automatic finish_test();
        test_count++;
        $display("test %s: %s (%0d errors)", test_name,
                 (error_count == test_errors) ? "ok" : "failed", error_count - test_errors);
    endtask

    task automatic check_count();
        assert (recv_count == sent_count) else begin
            $display("[ERROR] %s packet count: expected %0d actual %0d",
                     test_name, sent_count, recv_count);
            error_count++;
        end
    endtask

    // Every request strobe must match the next packet in send order
    always @(negedge ap_clk) begin
        if (!areset && request_engine_out.valid) begin
            expected_q = expected_payload(recv_count);
            assert (request_engine_out.payload == expected_q) else begin
                $display("[ERROR] %s packet %0d: expected %h actual %h",
                         test_name, recv_count, expected_q, request_engine_out.payload);
                error_count++;
            end
            recv_count++;
        end
    end

    // ------------------------------------------------
    // Tests
    // ------------------------------------------------
    task automatic check_idle_after_reset();
        start_test("reset_idle");
        repeat (10) begin
            @(negedge ap_clk);
            assert (!request_engine_out.valid) else begin
                $display("[ERROR] %s request valid: expected 0 actual 1", test_name);
                error_count++;
            end
            assert (fifo_response_status.empty) else begin
                $display("[ERROR] %s status empty: expected 1 actual 0", test_name);
                error_count++;
            end
        end
        finish_test();
    endtask

    task automatic stream_packets();
        start_test("streaming");
        response_rd_en = 1'b1;
        request_rd_en = 1'b1;
        send_burst(N_STREAM);
        wait_drained();
        idle_cycles(5);
        check_count();
        finish_test();
    endtask

    task automatic hold_input();
        int start_recv;
        start_test("input_hold");
        response_rd_en = 1'b0;
        idle_cycles(2);
        start_recv = recv_count;
        send_burst(N_HOLD);
        idle_cycles(20);
        assert (recv_count == start_recv) else begin
            $display("[ERROR] %s strobes while held: expected %0d actual %0d",
                     test_name, start_recv, recv_count);
            error_count++;
        end
        response_rd_en = 1'b1;
        // Enable register, FIFO read and status register
        idle_cycles(3);
        assert (fifo_response_status.rd_valid) else begin
            $display("[ERROR] %s status rd_valid: expected 1 actual 0", test_name);
            error_count++;
        end
        wait_drained();
        idle_cycles(5);
        check_count();
        finish_test();
    endtask

    task automatic apply_backpressure();
        int start_recv;
        int n;
        start_test("backpressure");
        request_rd_en = 1'b0;
        idle_cycles(2);
        start_recv = recv_count;
        n = 0;
        @(negedge ap_clk);
        // Sender stops as soon as the registered prog_full is seen
        while (!fifo_response_status.prog_full && n < N_BP_MAX) begin
            drive_next_packet();
            n++;
            @(negedge ap_clk);
        end
        response_engine_in.valid = 1'b0;
        assert (fifo_response_status.prog_full) else begin
            $display("%s: input FIFO never reported prog_full after %0d packets",
                     test_name, n);
            error_count++;
        end
        idle_cycles(20);
        assert (recv_count == start_recv) else begin
            $display("[ERROR] %s strobes while blocked: expected %0d actual %0d",
                     test_name, start_recv, recv_count);
            error_count++;
        end
        // Half the input FIFO is left as margin
        assert (!fifo_response_status.full) else begin
            $display("[ERROR] %s status full: expected 0 actual 1", test_name);
            error_count++;
        end
        request_rd_en = 1'b1;
        wait_drained();
        idle_cycles(5);
        check_count();
        finish_test();
    endtask

    task automatic check_done();
        start_test("done");
        send_burst(N_DONE);
        while (recv_count < sent_count) begin
            assert (!done_out) else begin
                $display("[ERROR] %s done with packets pending: expected 0 actual 1",
                         test_name);
                error_count++;
            end
            @(negedge ap_clk);
        end
        idle_cycles(20);
        assert (done_out) else begin
            $display("[ERROR] %s done after drain: expected 1 actual 0", test_name);
            error_count++;
        end
        check_count();
        finish_test();
    endtask

    // ------------------------------------------------
    // Sequence, timeout and final report
    // ------------------------------------------------
    initial begin
        areset = 1'b1;
        response_engine_in = '0;
        response_rd_en = 1'b0;
        request_rd_en = 1'b0;
        gen_state = SEED;
        sent_count = 0;
        recv_count = 0;
        error_count = 0;
        test_errors = 0;
        test_count = 0;
        test_name = "reset";
        expected_q = '0;
        repeat (16) @(negedge ap_clk);
        areset = 1'b0;
        // Internal reset is one register behind the port
        idle_cycles(2);
        check_idle_after_reset();
        stream_packets();
        hold_input();
        apply_backpressure();
        check_done();
        $display("Tests run %0d, packets sent %0d, received %0d, errors %0d",
                 test_count, sent_count, recv_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge ap_clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles in test %s, %0d of %0d packets received",
                 cycle_count, test_name, recv_count, sent_count);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
logic/engine_pkg.sv
logic/packet_fifo.sv
logic/engine_delay_pipeline.sv
logic/engine_egress.sv
logic/engine_pipeline_top.sv
testbench/engine_tb_top.sv

// File: Makefile
# Verilator build and run for the engine lane testbench

TOP := engine_tb_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal -f flist.f --top-module $(TOP) -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
